// File: filelist.f
verilog/dcache_pkg.sv
verilog/dcache_req_decode.sv
verilog/dcache_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_load_align.sv
verilog/dcache_top.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module dcache_tb \
    -f filelist.f \
    --Mdir obj_dir -o dcache_sim

./obj_dir/dcache_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation log is in sim.log"

// File: verification/dcache_stim.txt
# op addr size wdata expected, all fields hex
# op 0 load, 1 store; size 0 byte, 1 half, 2 word; expected is the zero-extended load data
0 00000100 2 00000000 a5a50100
0 00000105 0 00000000 00000001
0 0000010e 1 00000000 0000a5a5
1 00000108 2 12345678 00000000
1 00000109 0 abababab 00000000
0 00000108 2 00000000 1234ab78
0 00000109 0 00000000 000000ab
0 0000010a 1 00000000 00001234
1 00000106 1 beefbeef 00000000
0 00000104 2 00000000 beef0104
0 00001104 2 00000000 a5a51104
0 00001101 0 00000000 00000011
0 00000108 2 00000000 1234ab78
0 00000104 2 00000000 beef0104
1 00002208 2 cafef00d 00000000
0 00002208 2 00000000 cafef00d
0 0000220c 2 00000000 a5a5220c
0 00000304 1 00000000 00000304
0 00002208 2 00000000 cafef00d
1 000004f3 0 5a5a5a5a 00000000
0 000004f0 2 00000000 5aa504f0
0 000004f2 0 00000000 000000a5
0 00000a52 1 00000000 0000a5a5
0 00000a5c 2 00000000 a5a50a5c
0 12345670 2 00000000 b7915670
0 12345673 0 00000000 000000b7
1 0000f4f8 2 0badc0de 00000000
0 000004f0 2 00000000 5aa504f0
0 0000f4f8 2 00000000 0badc0de

// File: verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int    RESET_CYCLES  = 5;
    localparam int    CYCLES_PER_OP = 40;
    localparam string STIM_FILE     = "verification/dcache_stim.txt";

    logic                  clk = 1'b0;
    logic                  rstn;
    logic                  cpu_req;
    logic                  cpu_wr;
    dcache_pkg::addr_t     cpu_addr;
    dcache_pkg::data_t     cpu_wdata;
    dcache_pkg::size_e     cpu_size;
    logic                  cpu_ready;
    dcache_pkg::data_t     cpu_rdata;
    logic                  cpu_rvalid;
    logic                  mem_req;
    logic                  mem_we;
    dcache_pkg::addr_t     mem_addr;
    dcache_pkg::line_t     mem_wdata;
    logic                  mem_gnt;
    logic                  mem_rvalid;
    dcache_pkg::line_t     mem_rdata;

    logic [31:0]           stim_op[$];
    logic [31:0]           stim_addr[$];
    logic [31:0]           stim_size[$];
    logic [31:0]           stim_wdata[$];
    logic [31:0]           stim_exp[$];

    dcache_pkg::data_t     mem_words [dcache_pkg::addr_t];    // Written-back words only
    dcache_pkg::addr_t     cur_line_addr;
    int                    err_count   = 0;
    int                    op_count    = 0;
    int                    wb_count    = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 100000;

    always #10 clk = ~clk;

    dcache_top UUT (.*);

    bind dcache_top dcache_assertions u_assertions (
        .clk, .rstn, .mem_req, .mem_gnt, .mem_we, .mem_addr, .mem_wdata,
        .cpu_rvalid, .load_hit
    );

    function automatic dcache_pkg::data_t read_word(input dcache_pkg::addr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return a ^ 32'hA5A5_0000;    // Untouched memory
    endfunction

    function automatic dcache_pkg::line_t read_line(input dcache_pkg::addr_t base);
        dcache_pkg::line_t rd_line;
        for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
            rd_line[w*32 +: 32] = read_word(base + 4 * w);
        end
        return rd_line;
    endfunction

    task automatic write_line(input dcache_pkg::addr_t base, input dcache_pkg::line_t wr_line);
        for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
            mem_words[base + 4 * w] = wr_line[w*32 +: 32];
        end
    endtask

    task automatic read_stim();
        int          fd;
        int          n;
        string       text;
        logic [31:0] f_op, f_addr, f_size, f_wdata, f_exp;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0 && text[0] != "#") begin
                    n = $sscanf(text, "%h %h %h %h %h", f_op, f_addr, f_size, f_wdata, f_exp);
                    if (n == 5) begin
                        stim_op.push_back(f_op);
                        stim_addr.push_back(f_addr);
                        stim_size.push_back(f_size);
                        stim_wdata.push_back(f_wdata);
                        stim_exp.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_load(input int i, input logic valid, input dcache_pkg::data_t got);
        $display("Fail at %0t: load 0x%08h size %0d gave valid %0b data 0x%08h, expected 0x%08h",
                 $time, stim_addr[i], stim_size[i], valid, got, stim_exp[i]);
        err_count++;
    endtask

    // One CPU operation, entered and left on a falling edge with cpu_ready high
    task automatic run_op(input int i);
        logic              is_load;
        logic              early_rvalid;
        dcache_pkg::data_t early_rdata;
        is_load       = (stim_op[i] == 32'd0);
        cur_line_addr = {stim_addr[i][31:4], 4'h0};
        cpu_req       = 1'b1;
        cpu_wr        = !is_load;
        cpu_addr      = stim_addr[i];
        cpu_wdata     = stim_wdata[i];
        cpu_size      = dcache_pkg::size_e'(stim_size[i][1:0]);
        #5;
        early_rvalid = cpu_rvalid;    // Hit response is combinational
        early_rdata  = cpu_rdata;
        @(negedge clk);
        cpu_req = 1'b0;
        if (cpu_ready) begin
            if (is_load && (early_rvalid !== 1'b1 || early_rdata !== stim_exp[i])) begin
                report_load(i, early_rvalid, early_rdata);
            end
        end else begin
            while (!cpu_ready) begin
                @(negedge clk);
            end
            if (is_load && (cpu_rvalid !== 1'b1 || cpu_rdata !== stim_exp[i])) begin
                report_load(i, cpu_rvalid, cpu_rdata);
            end
            if (!is_load && cpu_rvalid !== 1'b0) begin
                $display("Fail at %0t: store miss to 0x%08h raised cpu_rvalid",
                         $time, stim_addr[i]);
                err_count++;
            end
        end
        op_count++;
    endtask

    // Memory with random grant and response delays
    initial begin : mem_model
        int                gnt_delay;
        int                rsp_delay;
        logic              req_we;
        dcache_pkg::addr_t req_addr;
        dcache_pkg::line_t req_line;
        void'($urandom(32'h2d09a933));
        mem_gnt    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (rstn && mem_req) begin
                gnt_delay = $urandom_range(3, 0);
                repeat (gnt_delay) @(negedge clk);
                req_we   = mem_we;
                req_addr = mem_addr;
                req_line = mem_wdata;
                mem_gnt  = 1'b1;
                @(negedge clk);
                mem_gnt = 1'b0;
                if (req_we) begin
                    write_line(req_addr, req_line);
                    wb_count++;
                end else begin
                    if (req_addr !== cur_line_addr) begin
                        $display("Fail at %0t: refill read of 0x%08h, expected 0x%08h",
                                 $time, req_addr, cur_line_addr);
                        err_count++;
                    end
                    rsp_delay = $urandom_range(3, 1);
                    repeat (rsp_delay - 1) @(negedge clk);
                    mem_rdata  = read_line(req_addr);
                    mem_rvalid = 1'b1;
                    @(negedge clk);
                    mem_rvalid = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        int total;
        rstn      = 1'b0;
        cpu_req   = 1'b0;
        cpu_wr    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_size  = dcache_pkg::SIZE_WORD;
        read_stim();
        if (stim_addr.size() == 0) begin
            $display("No stimulus could be read from %s", STIM_FILE);
            $display("Test failed");
            $finish;
        end else begin
            cycle_limit = RESET_CYCLES + CYCLES_PER_OP * stim_addr.size();
            repeat (RESET_CYCLES) @(negedge clk);
            rstn = 1'b1;
            if (cpu_ready !== 1'b1 || mem_req !== 1'b0 || cpu_rvalid !== 1'b0) begin
                $display("Fail at %0t: after reset ready %0b mem_req %0b rvalid %0b",
                         $time, cpu_ready, mem_req, cpu_rvalid);
                err_count++;
            end
            for (int i = 0; i < stim_addr.size(); i++) begin
                run_op(i);
            end
            if (wb_count == 0) begin
                $display("Fail at %0t: no writeback reached memory", $time);
                err_count++;
            end
            repeat (2) @(negedge clk);
            total = err_count + UUT.u_assertions.fail_count;
            $display("Operations %0d, writebacks %0d, value errors %0d, assertion failures %0d",
                     op_count, wb_count, err_count, UUT.u_assertions.fail_count);
            if (total == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/dcache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input wire                    clk,
    input wire                    rstn,
    input wire                    mem_req,
    input wire                    mem_gnt,
    input wire                    mem_we,
    input wire dcache_pkg::addr_t mem_addr,
    input wire dcache_pkg::line_t mem_wdata,
    input wire                    cpu_rvalid,
    input wire                    load_hit
);

    int fail_count = 0;

    // Request held steady until granted
    a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_gnt |=> $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata))
    else begin
        fail_count = fail_count + 1;
        $error("memory request changed while waiting for grant");
    end

    a_rvalid_once: assert property (@(posedge clk) disable iff (!rstn)
        cpu_rvalid && $past(cpu_rvalid) |-> load_hit)
    else begin
        fail_count = fail_count + 1;
        $error("cpu_rvalid high twice without a new load hit");
    end

    a_line_aligned: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |-> mem_addr[dcache_pkg::OFFSET_BITS-1:0] == '0)
    else begin
        fail_count = fail_count + 1;
        $error("memory address not line aligned");
    end

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        cpu_req,
    input  wire                        cpu_wr,
    input  wire dcache_pkg::addr_t     cpu_addr,
    input  wire dcache_pkg::data_t     cpu_wdata,
    input  wire dcache_pkg::size_e     cpu_size,
    output logic                       cpu_ready,
    output dcache_pkg::data_t          cpu_rdata,
    output logic                       cpu_rvalid,
    output logic                       mem_req,
    output logic                       mem_we,
    output dcache_pkg::addr_t          mem_addr,
    output dcache_pkg::line_t          mem_wdata,
    input  wire                        mem_gnt,
    input  wire                        mem_rvalid,
    input  wire dcache_pkg::line_t     mem_rdata
);

    dcache_pkg::index_t    cur_index;
    dcache_pkg::tag_t      cur_tag;
    dcache_pkg::word_off_t cur_word;
    logic [1:0]            cur_byte;
    dcache_pkg::strb_t     cur_strb;
    logic                  pend_wr;
    dcache_pkg::index_t    pend_index;
    dcache_pkg::tag_t      pend_tag;
    dcache_pkg::word_off_t pend_word;
    logic [1:0]            pend_byte;
    dcache_pkg::size_e     pend_size;
    dcache_pkg::data_t     pend_wdata;
    dcache_pkg::strb_t     pend_strb;
    dcache_pkg::addr_t     pend_line_addr;

    logic                  cur_hit;
    logic                  cur_dirty;
    dcache_pkg::line_t     cur_line;
    dcache_pkg::addr_t     victim_addr;
    dcache_pkg::line_t     victim_line;

    logic                  capture;
    logic                  hit_we;
    logic                  fill_we;
    logic                  load_hit;

    assign pend_line_addr = {pend_tag, pend_index, {dcache_pkg::OFFSET_BITS{1'b0}}};

    dcache_req_decode u_decode (.*);    // Input side

    dcache_store u_store (
        .clk, .rstn, .cur_index, .cur_tag, .pend_index, .pend_tag,
        .hit_we, .cur_word, .cur_strb, .cpu_wdata,
        .fill_we, .fill_line(mem_rdata),
        .pend_wr, .pend_word, .pend_wdata, .pend_strb,
        .cur_hit, .cur_dirty, .cur_line, .victim_addr, .victim_line
    );

    dcache_ctrl u_ctrl (.*);

    dcache_load_align u_align (
        .clk, .rstn, .load_hit, .cur_line, .cur_word, .cur_byte, .cpu_size,
        .fill_we, .pend_wr, .fill_line(mem_rdata), .pend_word, .pend_byte, .pend_size,
        .cpu_rdata, .cpu_rvalid
    );

endmodule

`default_nettype wire

// File: verilog/dcache_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_load_align (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        load_hit,
    input  wire dcache_pkg::line_t     cur_line,
    input  wire dcache_pkg::word_off_t cur_word,
    input  wire [1:0]                  cur_byte,
    input  wire dcache_pkg::size_e     cpu_size,
    input  wire                        fill_we,
    input  wire                        pend_wr,
    input  wire dcache_pkg::line_t     fill_line,
    input  wire dcache_pkg::word_off_t pend_word,
    input  wire [1:0]                  pend_byte,
    input  wire dcache_pkg::size_e     pend_size,
    output dcache_pkg::data_t          cpu_rdata,
    output logic                       cpu_rvalid
);

    logic              rvalid_q;
    dcache_pkg::data_t rdata_q;

    // Word select, then zero-extended byte or halfword
    function automatic dcache_pkg::data_t extract(
        input dcache_pkg::line_t     line,
        input dcache_pkg::word_off_t word,
        input logic [1:0]            byte_off,
        input dcache_pkg::size_e     size
    );
        dcache_pkg::data_t w;
        w = line[word*32 +: 32];
        case (size)
            dcache_pkg::SIZE_BYTE: return {24'h0, w[byte_off*8 +: 8]};
            dcache_pkg::SIZE_HALF: return {16'h0, w[byte_off[1]*16 +: 16]};
            default:               return w;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= fill_we && !pend_wr;    // Only a load miss answers
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            rdata_q <= extract(fill_line, pend_word, pend_byte, pend_size);
        end
    end

    assign cpu_rvalid = load_hit || rvalid_q;
    assign cpu_rdata  = load_hit ? extract(cur_line, cur_word, cur_byte, cpu_size) : rdata_q;

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        cpu_req,
    input  wire                        cpu_wr,
    input  wire                        cur_hit,
    input  wire                        cur_dirty,
    input  wire dcache_pkg::addr_t     victim_addr,
    input  wire dcache_pkg::line_t     victim_line,
    input  wire dcache_pkg::addr_t     pend_line_addr,
    input  wire                        mem_gnt,
    input  wire                        mem_rvalid,
    output logic                       cpu_ready,
    output logic                       capture,
    output logic                       hit_we,
    output logic                       fill_we,
    output logic                       load_hit,
    output logic                       mem_req,
    output logic                       mem_we,
    output dcache_pkg::addr_t          mem_addr,
    output dcache_pkg::line_t          mem_wdata
);

    dcache_pkg::state_e state;
    logic               accept;
    logic               mem_req_q;
    dcache_pkg::addr_t  wb_addr_q;
    dcache_pkg::line_t  wb_line_q;

    assign cpu_ready = (state == dcache_pkg::S_IDLE);
    assign accept    = cpu_req && cpu_ready;

    // Request classification in idle
    assign load_hit = accept && !cpu_wr && cur_hit;
    assign hit_we   = accept && cpu_wr && cur_hit;
    assign capture  = accept && !cur_hit;

    assign fill_we = (state == dcache_pkg::S_REFILL) && mem_rvalid;

    assign mem_req   = mem_req_q;
    assign mem_we    = (state == dcache_pkg::S_WRITEBACK);
    // Refill address comes straight from the pending register, stable for the whole miss
    assign mem_addr  = mem_we ? wb_addr_q : pend_line_addr;
    assign mem_wdata = wb_line_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= dcache_pkg::S_IDLE;
            mem_req_q <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::S_IDLE: begin
                    if (capture) begin
                        mem_req_q <= 1'b1;
                        state     <= cur_dirty ? dcache_pkg::S_WRITEBACK : dcache_pkg::S_REFILL;
                    end
                end
                dcache_pkg::S_WRITEBACK: begin
                    if (mem_gnt) begin
                        state <= dcache_pkg::S_REFILL;  // Request stays up for the read
                    end
                end
                dcache_pkg::S_REFILL: begin
                    if (mem_req_q && mem_gnt) begin
                        mem_req_q <= 1'b0;
                    end
                    if (mem_rvalid) begin
                        state <= dcache_pkg::S_IDLE;
                    end
                end
                default: begin
                    state     <= dcache_pkg::S_IDLE;
                    mem_req_q <= 1'b0;
                end
            endcase
        end
    end

    // Victim snapshot taken at the accepting edge
    always_ff @(posedge clk) begin
        if (capture && cur_dirty) begin
            wb_addr_q <= victim_addr;
            wb_line_q <= victim_line;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_store (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire dcache_pkg::index_t    cur_index,
    input  wire dcache_pkg::tag_t      cur_tag,
    input  wire dcache_pkg::index_t    pend_index,
    input  wire dcache_pkg::tag_t      pend_tag,
    input  wire                        hit_we,
    input  wire dcache_pkg::word_off_t cur_word,
    input  wire dcache_pkg::strb_t     cur_strb,
    input  wire dcache_pkg::data_t     cpu_wdata,
    input  wire                        fill_we,
    input  wire dcache_pkg::line_t     fill_line,
    input  wire                        pend_wr,
    input  wire dcache_pkg::word_off_t pend_word,
    input  wire dcache_pkg::data_t     pend_wdata,
    input  wire dcache_pkg::strb_t     pend_strb,
    output logic                       cur_hit,
    output logic                       cur_dirty,
    output dcache_pkg::line_t          cur_line,
    output dcache_pkg::addr_t          victim_addr,
    output dcache_pkg::line_t          victim_line
);

    dcache_pkg::tag_t             tags  [dcache_pkg::N_LINES];
    dcache_pkg::line_t            lines [dcache_pkg::N_LINES];
    logic [dcache_pkg::N_LINES-1:0] valid_q;
    logic [dcache_pkg::N_LINES-1:0] dirty_q;

    // Overwrite the strobed bytes of one word
    function automatic dcache_pkg::line_t merge_word(
        input dcache_pkg::line_t     line,
        input dcache_pkg::word_off_t word,
        input dcache_pkg::data_t     wdata,
        input dcache_pkg::strb_t     strb
    );
        dcache_pkg::line_t res;
        res = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[word*32 + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign cur_hit     = valid_q[cur_index] && (tags[cur_index] == cur_tag);
    assign cur_dirty   = valid_q[cur_index] && dirty_q[cur_index];
    assign cur_line    = lines[cur_index];
    assign victim_line = lines[cur_index];
    assign victim_addr = {tags[cur_index], cur_index, {dcache_pkg::OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we) begin
            valid_q[pend_index] <= 1'b1;
            dirty_q[pend_index] <= pend_wr;     // Clean unless a store miss
        end else if (hit_we) begin
            dirty_q[cur_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tags[pend_index]  <= pend_tag;
            lines[pend_index] <= pend_wr ?
                merge_word(fill_line, pend_word, pend_wdata, pend_strb) : fill_line;
        end else if (hit_we) begin
            lines[cur_index] <= merge_word(lines[cur_index], cur_word, cpu_wdata, cur_strb);
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_decode (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        capture,
    input  wire dcache_pkg::addr_t     cpu_addr,
    input  wire                        cpu_wr,
    input  wire dcache_pkg::data_t     cpu_wdata,
    input  wire dcache_pkg::size_e     cpu_size,
    output dcache_pkg::index_t         cur_index,
    output dcache_pkg::tag_t           cur_tag,
    output dcache_pkg::word_off_t      cur_word,
    output logic [1:0]                 cur_byte,
    output dcache_pkg::strb_t          cur_strb,
    output logic                       pend_wr,
    output dcache_pkg::index_t         pend_index,
    output dcache_pkg::tag_t           pend_tag,
    output dcache_pkg::word_off_t      pend_word,
    output logic [1:0]                 pend_byte,
    output dcache_pkg::size_e          pend_size,
    output dcache_pkg::data_t          pend_wdata,
    output dcache_pkg::strb_t          pend_strb
);

    assign cur_tag   = cpu_addr[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_BITS];
    assign cur_index = cpu_addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::IDX_BITS];
    assign cur_word  = cpu_addr[dcache_pkg::OFFSET_BITS-1:2];
    assign cur_byte  = cpu_addr[1:0];

    // Byte lanes from size and low address bits
    always_comb begin
        case (cpu_size)
            dcache_pkg::SIZE_BYTE: cur_strb = 4'b0001 << cur_byte;
            dcache_pkg::SIZE_HALF: cur_strb = cur_byte[1] ? 4'b1100 : 4'b0011;
            default:               cur_strb = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend_wr <= 1'b0;
        end else if (capture) begin
            pend_wr <= cpu_wr;
        end
    end

    // Miss request kept for the refill
    always_ff @(posedge clk) begin
        if (capture) begin
            pend_index <= cur_index;
            pend_tag   <= cur_tag;
            pend_word  <= cur_word;
            pend_byte  <= cur_byte;
            pend_size  <= cpu_size;
            pend_wdata <= cpu_wdata;
            pend_strb  <= cur_strb;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int LINE_BYTES     = 16;
    localparam int N_LINES        = 16;
    localparam int OFFSET_BITS    = $clog2(LINE_BYTES);
    localparam int IDX_BITS       = $clog2(N_LINES);
    localparam int TAG_BITS       = ADDR_WIDTH - OFFSET_BITS - IDX_BITS;
    localparam int WORDS_PER_LINE = LINE_BYTES / 4;
    localparam int WORD_OFF_BITS  = $clog2(WORDS_PER_LINE);

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [31:0]               data_t;
    typedef logic [3:0]                strb_t;
    typedef logic [LINE_BYTES*8-1:0]   line_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [IDX_BITS-1:0]       index_t;
    typedef logic [WORD_OFF_BITS-1:0]  word_off_t;

    // Access size as seen on the CPU port
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } size_e;

    typedef enum logic [1:0] {
        S_IDLE      = 2'b00,    // Accepting CPU requests
        S_WRITEBACK = 2'b01,    // Dirty victim going out
        S_REFILL    = 2'b10     // Waiting for the new line
    } state_e;

endpackage

`default_nettype wire
